// ==== Bender.yml ====
package:
  name: rp_analog

export_include_dirs:
  - .

sources:
  - rp_analog_pkg.sv
  - rp_sample_if.sv
  - rp_cal_regs.sv
  - rp_linear.sv
  - rp_adc_frontend.sv
  - rp_dac_backend.sv
  - rp_analog_top.sv
  - target: test
    files:
      - tb_rp_analog.sv

// ==== flist.f ====
+incdir+.
rp_analog_pkg.sv
rp_sample_if.sv
rp_cal_regs.sv
rp_linear.sv
rp_adc_frontend.sv
rp_dac_backend.sv
rp_analog_top.sv
tb_rp_analog.sv

// ==== rp_adc_frontend.sv ====
// adc pad capture with sign conversion and loopback select
// the output register only loads when empty or accepted downstream
// pad samples arriving during a stall are lost, the held one stays
// vld is high from the first cycle after reset on
`default_nettype none

module rp_adc_frontend
  import rp_analog_pkg::*;
(
  input  wire          adc_clk,
  input  wire          rst_n_i,
  // adc pads
  input  pad_code_t    adc_dat_a_i,
  input  pad_code_t    adc_dat_b_i,
  // loopback from dac path
  input  wire          digital_loop_i,
  input  sample_pair_t loop_dat_i,
  // stream to adc calibration
  rp_sample_if.src     smp
);

  sample_pair_t pad_smp;  // pads in two's complement
  sample_pair_t mux_smp;
  sample_pair_t dat_q;
  logic         vld_q;
  logic         ld;       // output register may load

  assign pad_smp[0] = pad_to_smp(adc_dat_a_i);
  assign pad_smp[1] = pad_to_smp(adc_dat_b_i);

  assign mux_smp = digital_loop_i ? loop_dat_i : pad_smp;

  assign ld      = ~vld_q | smp.rdy;
  assign smp.vld = vld_q;
  assign smp.dat = dat_q;

  // free running source, always has a sample once out of reset
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
      vld_q <= 1'b0;
    else
      vld_q <= 1'b1;
  end

  // hold on stall
  always_ff @(posedge adc_clk)
  begin
    if (ld)
      dat_q <= mux_smp;
  end

endmodule

`default_nettype wire

// ==== rp_analog_defines.svh ====
// widths, unity gain and register map of the analog path
// gain is fixed point with RP_GAIN_SHIFT fraction bits, keep RP_GAIN_ONE in step
// register offsets are byte offsets inside the single bus region
`ifndef RP_ANALOG_DEFINES_SVH
`define RP_ANALOG_DEFINES_SVH

// datapath
`define RP_DW          14     // adc/dac sample width
`define RP_DWM         16     // gain width
`define RP_GAIN_SHIFT  14     // product scaling
`define RP_GAIN_ONE    16384  // unity gain

// system bus
`define RP_BUS_AW          8      // decoded address bits
`define RP_REG_CTRL        8'h00  // bit 0 digital loopback
`define RP_REG_ADC_GAIN_A  8'h10
`define RP_REG_ADC_GAIN_B  8'h14
`define RP_REG_ADC_OFS_A   8'h18
`define RP_REG_ADC_OFS_B   8'h1C
`define RP_REG_DAC_GAIN_A  8'h20
`define RP_REG_DAC_GAIN_B  8'h24
`define RP_REG_DAC_OFS_A   8'h28
`define RP_REG_DAC_OFS_B   8'h2C

`endif

// ==== rp_analog_pkg.sv ====
// types shared by the analog path
// pair index 0 is channel a, index 1 is channel b
// pad codes are unsigned with negative slope, as the converters use them
`default_nettype none

`include "rp_analog_defines.svh"

package rp_analog_pkg;

  typedef logic signed [`RP_DW-1:0]  sample_t;    // two's complement
  typedef logic        [`RP_DW-1:0]  pad_code_t;  // neg-slope pad code
  typedef sample_t     [1:0]         sample_pair_t;

  typedef logic signed [`RP_DWM-1:0] gain_t;
  typedef logic signed [`RP_DW-1:0]  offset_t;

  // one channel of calibration
  typedef struct packed {
    gain_t   gain;
    offset_t ofs;
  } cal_cfg_t;

  typedef cal_cfg_t [1:0] cal_pair_t;

  // the same bit flip works in both directions
  function automatic sample_t pad_to_smp (pad_code_t code);
    return {code[`RP_DW-1], ~code[`RP_DW-2:0]};
  endfunction

  function automatic pad_code_t smp_to_pad (sample_t smp);
    return {smp[`RP_DW-1], ~smp[`RP_DW-2:0]};  // zero maps to 0x1fff
  endfunction

endpackage

`default_nettype wire

// ==== rp_analog_top.sv ====
// two channel analog path, single clock adc_clk
// adc result and dac input are valid/ready streams on plain ports
// latency 3 cycles on each path, 6 from dac input to adc output in loopback
`default_nettype none

module rp_analog_top
  import rp_analog_pkg::*;
(
  input  wire         adc_clk,
  input  wire         rst_n_i,
  // adc pads and result stream
  input  pad_code_t   adc_dat_a_i,
  input  pad_code_t   adc_dat_b_i,
  output sample_t     adc_dat_a_o,
  output sample_t     adc_dat_b_o,
  output logic        adc_vld_o,
  input  wire         adc_rdy_i,
  // dac input stream and pads
  input  sample_t     dac_in_a_i,
  input  sample_t     dac_in_b_i,
  input  wire         dac_vld_i,
  output logic        dac_rdy_o,
  output pad_code_t   dac_dat_a_o,
  output pad_code_t   dac_dat_b_o,
  // system bus
  input  wire  [31:0] sys_addr_i,
  input  wire  [31:0] sys_wdata_i,
  input  wire         sys_wen_i,
  input  wire         sys_ren_i,
  output logic [31:0] sys_rdata_o,
  output logic        sys_ack_o,
  output logic        sys_err_o
);

  logic         digital_loop;
  cal_pair_t    adc_cfg;
  cal_pair_t    dac_cfg;
  sample_pair_t loop_dat;      // last dac sample for loopback

  rp_sample_if adc_raw ();     // frontend to adc calibration
  rp_sample_if adc_res ();     // adc calibration to ports
  rp_sample_if dac_src ();     // ports to dac calibration
  rp_sample_if dac_cal ();     // dac calibration to backend

  // plain ports <-> streams
  assign dac_src.dat = {dac_in_b_i, dac_in_a_i};
  assign dac_src.vld = dac_vld_i;
  assign dac_rdy_o   = dac_src.rdy;
  assign adc_dat_a_o = adc_res.dat[0];
  assign adc_dat_b_o = adc_res.dat[1];
  assign adc_vld_o   = adc_res.vld;
  assign adc_res.rdy = adc_rdy_i;

  rp_cal_regs regs (
    .adc_clk (adc_clk), .rst_n_i (rst_n_i),
    .sys_addr_i (sys_addr_i), .sys_wdata_i (sys_wdata_i),
    .sys_wen_i (sys_wen_i), .sys_ren_i (sys_ren_i), .sys_rdata_o (sys_rdata_o),
    .sys_ack_o (sys_ack_o), .sys_err_o (sys_err_o),
    .digital_loop_o (digital_loop), .adc_cal_o (adc_cfg), .dac_cal_o (dac_cfg)
  );

  rp_adc_frontend adc_fe (
    .adc_clk (adc_clk), .rst_n_i (rst_n_i),
    .adc_dat_a_i (adc_dat_a_i), .adc_dat_b_i (adc_dat_b_i),
    .digital_loop_i (digital_loop), .loop_dat_i (loop_dat), .smp (adc_raw)
  );

  rp_linear adc_lin (.adc_clk (adc_clk), .rst_n_i (rst_n_i), .sti (adc_raw),
                     .sto (adc_res), .cfg_i (adc_cfg));

  rp_linear dac_lin (.adc_clk (adc_clk), .rst_n_i (rst_n_i), .sti (dac_src),
                     .sto (dac_cal), .cfg_i (dac_cfg));

  rp_dac_backend dac_be (
    .adc_clk (adc_clk), .rst_n_i (rst_n_i), .smp (dac_cal),
    .dac_dat_a_o (dac_dat_a_o), .dac_dat_b_o (dac_dat_b_o), .loop_dat_o (loop_dat)
  );

endmodule

`default_nettype wire

// ==== rp_cal_regs.sv ====
// register bank for loopback and calibration in a single bus region
// only the low RP_BUS_AW address bits are decoded so upper bits alias
// every request is acked one cycle later and unmapped offsets also raise err
// gains read back zero-extended and offsets sign-extended
`default_nettype none

`include "rp_analog_defines.svh"

module rp_cal_regs
  import rp_analog_pkg::*;
(
  input  wire         adc_clk,
  input  wire         rst_n_i,
  // system bus
  input  wire  [31:0] sys_addr_i,
  input  wire  [31:0] sys_wdata_i,
  input  wire         sys_wen_i,
  input  wire         sys_ren_i,
  output logic [31:0] sys_rdata_o,
  output logic        sys_ack_o,
  output logic        sys_err_o,
  // configuration
  output logic        digital_loop_o,
  output cal_pair_t   adc_cal_o,
  output cal_pair_t   dac_cal_o
);

  localparam cal_cfg_t CAL_DEFAULT = '{gain: gain_t'(`RP_GAIN_ONE), ofs: '0};

  logic [`RP_BUS_AW-1:0] addr;    // offset inside region
  logic                  req;     // read or write this cycle
  logic                  hit;     // offset is mapped
  logic [31:0]           rd_val;

  function automatic logic [31:0] gain_word (gain_t g);
    return {{(32-`RP_DWM){1'b0}}, g};
  endfunction

  function automatic logic [31:0] ofs_word (offset_t o);
    return {{(32-`RP_DW){o[`RP_DW-1]}}, o};
  endfunction

  assign addr = sys_addr_i[`RP_BUS_AW-1:0];
  assign req  = sys_wen_i | sys_ren_i;

  ////////////////////////////////////////////////////////////////////////////
  // decode and read mux
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    hit    = 1'b1;
    rd_val = '0;
    case (addr)
      `RP_REG_CTRL       : rd_val = {31'd0, digital_loop_o};
      `RP_REG_ADC_GAIN_A : rd_val = gain_word(adc_cal_o[0].gain);
      `RP_REG_ADC_GAIN_B : rd_val = gain_word(adc_cal_o[1].gain);
      `RP_REG_ADC_OFS_A  : rd_val = ofs_word(adc_cal_o[0].ofs);
      `RP_REG_ADC_OFS_B  : rd_val = ofs_word(adc_cal_o[1].ofs);
      `RP_REG_DAC_GAIN_A : rd_val = gain_word(dac_cal_o[0].gain);
      `RP_REG_DAC_GAIN_B : rd_val = gain_word(dac_cal_o[1].gain);
      `RP_REG_DAC_OFS_A  : rd_val = ofs_word(dac_cal_o[0].ofs);
      `RP_REG_DAC_OFS_B  : rd_val = ofs_word(dac_cal_o[1].ofs);
      default            : hit = 1'b0;
    endcase
  end

  // new values reach the pipes from the next cycle on
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      digital_loop_o <= 1'b0;
      adc_cal_o      <= {CAL_DEFAULT, CAL_DEFAULT};  // unity gain and no offset
      dac_cal_o      <= {CAL_DEFAULT, CAL_DEFAULT};
    end
    else if (sys_wen_i)
    begin
      case (addr)
        `RP_REG_CTRL       : digital_loop_o    <= sys_wdata_i[0];
        `RP_REG_ADC_GAIN_A : adc_cal_o[0].gain <= sys_wdata_i[`RP_DWM-1:0];
        `RP_REG_ADC_GAIN_B : adc_cal_o[1].gain <= sys_wdata_i[`RP_DWM-1:0];
        `RP_REG_ADC_OFS_A  : adc_cal_o[0].ofs  <= sys_wdata_i[`RP_DW-1:0];
        `RP_REG_ADC_OFS_B  : adc_cal_o[1].ofs  <= sys_wdata_i[`RP_DW-1:0];
        `RP_REG_DAC_GAIN_A : dac_cal_o[0].gain <= sys_wdata_i[`RP_DWM-1:0];
        `RP_REG_DAC_GAIN_B : dac_cal_o[1].gain <= sys_wdata_i[`RP_DWM-1:0];
        `RP_REG_DAC_OFS_A  : dac_cal_o[0].ofs  <= sys_wdata_i[`RP_DW-1:0];
        `RP_REG_DAC_OFS_B  : dac_cal_o[1].ofs  <= sys_wdata_i[`RP_DW-1:0];
        default            : ;  // unmapped write is dropped
      endcase
    end
  end

  // ack and err one cycle after the request
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      sys_ack_o <= 1'b0;
      sys_err_o <= 1'b0;
    end
    else
    begin
      sys_ack_o <= req;
      sys_err_o <= req & ~hit;
    end
  end

  always_ff @(posedge adc_clk)
  begin
    if (sys_ren_i)
      sys_rdata_o <= rd_val;  // zero for unmapped offsets
  end

endmodule

`default_nettype wire

// ==== rp_dac_backend.sv ====
// dac sink, ready every cycle once out of reset
// pad codes and the loopback pair update one cycle after each transfer
// pads reset to the code for zero, 0x1fff
`default_nettype none

module rp_dac_backend
  import rp_analog_pkg::*;
(
  input  wire          adc_clk,
  input  wire          rst_n_i,
  // stream from dac calibration
  rp_sample_if.dst     smp,
  // dac pads
  output pad_code_t    dac_dat_a_o,
  output pad_code_t    dac_dat_b_o,
  // last calibrated pair, back to the adc side
  output sample_pair_t loop_dat_o
);

  logic rdy_q;  // sink ready
  logic xfer;   // transfer this cycle

  assign smp.rdy = rdy_q;
  assign xfer    = smp.vld & rdy_q;

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
      rdy_q <= 1'b0;
    else
      rdy_q <= 1'b1;  // never back-pressures
  end

  ////////////////////////////////////////////////////////////////////////////
  // output registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      dac_dat_a_o <= smp_to_pad('0);  // mid scale
      dac_dat_b_o <= smp_to_pad('0);
      loop_dat_o  <= '0;
    end
    else if (xfer)
    begin
      // signed to neg-slope unsigned
      dac_dat_a_o <= smp_to_pad(smp.dat[0]);
      dac_dat_b_o <= smp_to_pad(smp.dat[1]);
      loop_dat_o  <= smp.dat;          // held between transfers
    end
  end

endmodule

`default_nettype wire

// ==== rp_linear.sv ====
// two stage calibration, out = sat14((x * gain) >>> RP_GAIN_SHIFT + offset)
// a gain of RP_GAIN_ONE is unity
// both stages advance together, a stall at the output freezes the pipe
// the offset travels with its product so a register write never splits a sample
`default_nettype none

`include "rp_analog_defines.svh"

module rp_linear
  import rp_analog_pkg::*;
(
  input  wire       adc_clk,
  input  wire       rst_n_i,
  rp_sample_if.dst  sti,      // input stream
  rp_sample_if.src  sto,      // output stream
  input  cal_pair_t cfg_i     // per channel gain and offset
);

  localparam int PW = `RP_DW + `RP_DWM;         // full product width
  localparam int SW = PW - `RP_GAIN_SHIFT + 1;  // scaled product plus offset

  logic                 adv;       // whole pipe moves
  logic                 vld1_q;    // stage 1 holds an item
  logic                 vld2_q;    // stage 2 holds an item

  logic signed [PW-1:0] prod_d [2];
  logic signed [PW-1:0] prod_q [2];
  offset_t              ofs_q  [2];
  logic signed [PW-1:0] shf    [2];
  logic signed [SW-1:0] sum    [2];
  sample_pair_t         sat_d;
  sample_pair_t         dat_q;

  assign adv     = ~vld2_q | sto.rdy;
  assign sti.rdy = adv;             // accept whenever the pipe moves
  assign sto.vld = vld2_q;
  assign sto.dat = dat_q;

  ////////////////////////////////////////////////////////////////////////////
  // stage 1, products
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    for (int i = 0; i < 2; i++)
      prod_d[i] = $signed(sti.dat[i]) * $signed(cfg_i[i].gain);
  end

  always_ff @(posedge adc_clk)
  begin
    if (adv)
    begin
      for (int i = 0; i < 2; i++)
      begin
        prod_q[i] <= prod_d[i];
        ofs_q[i]  <= cfg_i[i].ofs;  // offset sampled with its product
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stage 2, scale, offset, saturate
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    for (int i = 0; i < 2; i++)
    begin
      shf[i] = prod_q[i] >>> `RP_GAIN_SHIFT;
      sum[i] = $signed(shf[i][SW-2:0]) + ofs_q[i];  // both sign extended
      // top bits all equal means the sum fits in 14 bits
      if (&sum[i][SW-1:`RP_DW-1] || ~|sum[i][SW-1:`RP_DW-1])
        sat_d[i] = sum[i][`RP_DW-1:0];
      else
        sat_d[i] = {sum[i][SW-1], {(`RP_DW-1){~sum[i][SW-1]}}};  // clip
    end
  end

  always_ff @(posedge adc_clk)
  begin
    if (adv)
      dat_q <= sat_d;
  end

  // valid bits follow the data through both stages
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      vld1_q <= 1'b0;
      vld2_q <= 1'b0;
    end
    else if (adv)
    begin
      vld1_q <= sti.vld;
      vld2_q <= vld1_q;
    end
  end

endmodule

`default_nettype wire

// ==== rp_sample_if.sv ====
// sample pair stream with valid/ready
// a transfer happens on a clock edge where vld and rdy are both high
// the source keeps dat stable while vld is high and rdy is low
`default_nettype none

interface rp_sample_if;

  rp_analog_pkg::sample_pair_t dat;  // channel a in [0], b in [1]
  logic                        vld;
  logic                        rdy;

  // producer side
  modport src (
    output dat,
    output vld,
    input  rdy
  );

  // consumer side
  modport dst (
    input  dat,
    input  vld,
    output rdy
  );

endinterface

`default_nettype wire

// ==== tb_rp_analog.sv ====
// directed testbench for the analog top level with a single clock of period 4
// expected values come from local models of the pad flip and calibration rule
// latency is 3 on each path and 6 in loopback with adc_rdy_i high
`default_nettype none

`include "rp_analog_defines.svh"

module tb_rp_analog;
  import rp_analog_pkg::*;

  localparam int MAX_CYCLES = 500;  // about twice the 250 cycles of all tests

  logic adc_clk, rst_n_i, adc_vld_o, adc_rdy_i, dac_vld_i, dac_rdy_o;
  pad_code_t adc_dat_a_i, adc_dat_b_i, dac_dat_a_o, dac_dat_b_o;
  sample_t adc_dat_a_o, adc_dat_b_o, dac_in_a_i, dac_in_b_i;
  logic [31:0] sys_addr_i, sys_wdata_i, sys_rdata_o;
  logic sys_wen_i, sys_ren_i, sys_ack_o, sys_err_o;

  integer seed = 32'h9b5b0fab;
  int err_cnt = 0;
  int chk_cnt = 0;
  int test_cnt = 0;
  int cycles = 0;

  // register shadow with channel a at index 0
  logic loop_sh;
  gain_t adc_g [2];
  gain_t dac_g [2];
  offset_t adc_o [2];
  offset_t dac_o [2];

  // stimulus queues
  pad_code_t pa [$];
  pad_code_t pb [$];
  sample_t da [$];
  sample_t db [$];

  rp_analog_top dut (.*);

  initial
  begin
    adc_clk = 1'b0;
    forever #2 adc_clk = ~adc_clk;
  end

  // run limit
  always @(posedge adc_clk)
  begin
    cycles++;
    if (cycles >= MAX_CYCLES)
    begin
      $display("timeout, run stopped after %0d cycles", cycles);
      $display("Test failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // models
  ////////////////////////////////////////////////////////////////////////////

  function automatic sample_t to_sample(pad_code_t c);
    return {c[13], ~c[12:0]};  // top bit kept and the rest inverted
  endfunction

  function automatic pad_code_t to_pad(sample_t s);
    return {s[13], ~s[12:0]};
  endfunction

  function automatic sample_t apply_cal(sample_t x, gain_t g, offset_t o);
    longint p;
    p = longint'(x) * longint'(g);
    p = (p >>> 14) + longint'(o);
    if (p > 8191)
      p = 8191;   // clip high
    else if (p < -8192)
      p = -8192;
    return sample_t'(p);
  endfunction

  function automatic bit is_mapped(logic [7:0] a);
    return a inside {`RP_REG_CTRL, `RP_REG_ADC_GAIN_A, `RP_REG_ADC_GAIN_B,
                     `RP_REG_ADC_OFS_A, `RP_REG_ADC_OFS_B, `RP_REG_DAC_GAIN_A,
                     `RP_REG_DAC_GAIN_B, `RP_REG_DAC_OFS_A, `RP_REG_DAC_OFS_B};
  endfunction

  function automatic logic [31:0] expected_word(logic [7:0] a);
    case (a)
      `RP_REG_CTRL       : return {31'd0, loop_sh};
      `RP_REG_ADC_GAIN_A : return {16'd0, adc_g[0]};     // zero extended
      `RP_REG_ADC_GAIN_B : return {16'd0, adc_g[1]};
      `RP_REG_ADC_OFS_A  : return 32'(signed'(adc_o[0]));  // sign extended
      `RP_REG_ADC_OFS_B  : return 32'(signed'(adc_o[1]));
      `RP_REG_DAC_GAIN_A : return {16'd0, dac_g[0]};
      `RP_REG_DAC_GAIN_B : return {16'd0, dac_g[1]};
      `RP_REG_DAC_OFS_A  : return 32'(signed'(dac_o[0]));
      `RP_REG_DAC_OFS_B  : return 32'(signed'(dac_o[1]));
      default            : return 32'd0;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_sample(string name, sample_t got, sample_t exp);
    chk_cnt++;
    if (got !== exp)
    begin
      err_cnt++;
      $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_pad(string name, pad_code_t got, pad_code_t exp);
    chk_cnt++;
    if (got !== exp)
    begin
      err_cnt++;
      $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_word(string name, logic [31:0] got, logic [31:0] exp);
    chk_cnt++;
    if (got !== exp)
    begin
      err_cnt++;
      $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  // ack one cycle after the request and err only when unmapped
  task automatic check_ack(logic [7:0] a);
    chk_cnt++;
    if (sys_ack_o !== 1'b1 || sys_err_o !== !is_mapped(a))
    begin
      err_cnt++;
      $display("bus answer wrong for offset 0x%h, ack %b err %b", a, sys_ack_o, sys_err_o);
    end
  endtask

  task automatic finish_test(string name, int errs_before);
    test_cnt++;
    $display("test %s: %s", name, (err_cnt == errs_before) ? "ok" : "errors seen");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // bus and stream drivers
  ////////////////////////////////////////////////////////////////////////////

  task automatic reg_write(logic [7:0] a, logic [31:0] d);
    @(posedge adc_clk); #1;
    sys_addr_i = {24'd0, a};
    sys_wdata_i = d;
    sys_wen_i = 1'b1;
    @(posedge adc_clk); #1;
    sys_wen_i = 1'b0;
    check_ack(a);
    case (a)
      `RP_REG_CTRL       : loop_sh = d[0];
      `RP_REG_ADC_GAIN_A : adc_g[0] = d[15:0];
      `RP_REG_ADC_GAIN_B : adc_g[1] = d[15:0];
      `RP_REG_ADC_OFS_A  : adc_o[0] = d[13:0];
      `RP_REG_ADC_OFS_B  : adc_o[1] = d[13:0];
      `RP_REG_DAC_GAIN_A : dac_g[0] = d[15:0];
      `RP_REG_DAC_GAIN_B : dac_g[1] = d[15:0];
      `RP_REG_DAC_OFS_A  : dac_o[0] = d[13:0];
      `RP_REG_DAC_OFS_B  : dac_o[1] = d[13:0];
      default            : ;
    endcase
  endtask

  task automatic reg_read_check(logic [7:0] a);
    @(posedge adc_clk); #1;
    sys_addr_i = {24'd0, a};
    sys_ren_i = 1'b1;
    @(posedge adc_clk); #1;
    sys_ren_i = 1'b0;
    check_ack(a);
    check_word("sys_rdata_o", sys_rdata_o, expected_word(a));
  endtask

  task automatic read_all_regs();
    logic [7:0] offs [9];
    offs = '{8'h00, 8'h10, 8'h14, 8'h18, 8'h1C, 8'h20, 8'h24, 8'h28, 8'h2C};
    foreach (offs[k])
      reg_read_check(offs[k]);
  endtask

  // one pa/pb pair per cycle with results 3 cycles later
  task automatic adc_stream();
    int n;
    n = pa.size();
    for (int i = 0; i < n + 3; i++)
    begin
      @(posedge adc_clk); #1;
      if (i < n)
      begin
        adc_dat_a_i = pa[i];
        adc_dat_b_i = pb[i];
      end
      if (i >= 3)
      begin
        check_word("adc_vld_o", 32'(adc_vld_o), 32'd1);
        check_sample("adc_dat_a_o", adc_dat_a_o,
                     apply_cal(to_sample(pa[i-3]), adc_g[0], adc_o[0]));
        check_sample("adc_dat_b_o", adc_dat_b_o,
                     apply_cal(to_sample(pb[i-3]), adc_g[1], adc_o[1]));
      end
    end
  endtask

  // da/db pairs give pads 3 cycles later and the adc result 6 later in loopback
  task automatic dac_stream();
    int n;
    sample_t ca, cb;
    n = da.size();
    for (int i = 0; i < n + (loop_sh ? 6 : 3); i++)
    begin
      @(posedge adc_clk); #1;
      dac_vld_i = (i < n);
      if (i < n)
      begin
        dac_in_a_i = da[i];
        dac_in_b_i = db[i];
        check_word("dac_rdy_o", 32'(dac_rdy_o), 32'd1);
      end
      if (i >= 3 && i - 3 < n)
      begin
        check_pad("dac_dat_a_o", dac_dat_a_o, to_pad(apply_cal(da[i-3], dac_g[0], dac_o[0])));
        check_pad("dac_dat_b_o", dac_dat_b_o, to_pad(apply_cal(db[i-3], dac_g[1], dac_o[1])));
      end
      if (loop_sh && i >= 6)
      begin
        ca = apply_cal(da[i-6], dac_g[0], dac_o[0]);
        cb = apply_cal(db[i-6], dac_g[1], dac_o[1]);
        check_sample("adc_dat_a_o", adc_dat_a_o, apply_cal(ca, adc_g[0], adc_o[0]));
        check_sample("adc_dat_b_o", adc_dat_b_o, apply_cal(cb, adc_g[1], adc_o[1]));
      end
    end
  endtask

  task automatic fill_random_pads(int n);
    pa.delete();
    pb.delete();
    repeat (n)
    begin
      pa.push_back(pad_code_t'($random(seed)));
      pb.push_back(pad_code_t'($random(seed)));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_reset_state();
    int e0;
    e0 = err_cnt;
    rst_n_i = 1'b0;
    repeat (8) @(posedge adc_clk);
    #1;
    check_word("adc_vld_o", 32'(adc_vld_o), 32'd0);
    check_word("sys_ack_o", 32'(sys_ack_o), 32'd0);
    check_word("sys_err_o", 32'(sys_err_o), 32'd0);
    check_word("dac_rdy_o", 32'(dac_rdy_o), 32'd1);
    check_pad("dac_dat_a_o", dac_dat_a_o, 14'h1FFF);  // code for zero
    check_pad("dac_dat_b_o", dac_dat_b_o, 14'h1FFF);
    rst_n_i = 1'b1;
    read_all_regs();
    finish_test("reset state", e0);
  endtask

  task automatic test_adc_unity();
    int e0;
    e0 = err_cnt;
    fill_random_pads(40);
    adc_stream();
    finish_test("adc path at unity", e0);
  endtask

  task automatic test_adc_cal();
    int e0;
    e0 = err_cnt;
    reg_write(`RP_REG_ADC_GAIN_A, 32'd20000);
    reg_write(`RP_REG_ADC_GAIN_B, 32'd9000);
    reg_write(`RP_REG_ADC_OFS_A, 32'd100);
    reg_write(`RP_REG_ADC_OFS_B, -32'sd50);
    read_all_regs();
    fill_random_pads(12);
    // full scale of both signs where 0x0000 is +8191 and 0x3fff is -8192
    pa.push_back(14'h0000);
    pb.push_back(14'h3FFF);
    pa.push_back(14'h3FFF);
    pb.push_back(14'h0000);
    adc_stream();
    // gain 20000 on channel a must hit both clip levels
    @(posedge adc_clk); #1;
    adc_dat_a_i = 14'h0000;
    repeat (3) @(posedge adc_clk);
    #1;
    check_sample("adc_dat_a_o", adc_dat_a_o, 14'h1FFF);
    adc_dat_a_i = 14'h3FFF;
    repeat (3) @(posedge adc_clk);
    #1;
    check_sample("adc_dat_a_o", adc_dat_a_o, 14'h2000);
    finish_test("adc calibration and saturation", e0);
  endtask

  task automatic test_dac_path();
    int e0;
    e0 = err_cnt;
    reg_write(`RP_REG_DAC_GAIN_A, 32'd12000);
    reg_write(`RP_REG_DAC_GAIN_B, 32'd30000);
    reg_write(`RP_REG_DAC_OFS_A, -32'sd300);
    reg_write(`RP_REG_DAC_OFS_B, 32'd77);
    da.delete();
    db.delete();
    repeat (40)
    begin
      da.push_back(sample_t'($random(seed)));
      db.push_back(sample_t'($random(seed)));
    end
    dac_stream();
    finish_test("dac path", e0);
  endtask

  task automatic test_loopback();
    int e0;
    e0 = err_cnt;
    reg_write(`RP_REG_CTRL, 32'd1);
    da.delete();
    db.delete();
    repeat (20)
    begin
      da.push_back(sample_t'($random(seed)));
      db.push_back(sample_t'($random(seed)));
    end
    dac_stream();
    reg_write(`RP_REG_CTRL, 32'd0);
    finish_test("digital loopback", e0);
  endtask

  task automatic test_stall_and_err();
    int e0;
    sample_t ha, hb;
    e0 = err_cnt;
    repeat (6) @(posedge adc_clk);  // drain loopback samples
    #1;
    adc_rdy_i = 1'b0;
    ha = adc_dat_a_o;
    hb = adc_dat_b_o;
    for (int k = 0; k < 10; k++)
    begin
      @(posedge adc_clk); #1;
      adc_dat_a_i = pad_code_t'($random(seed));  // lost during the stall
      adc_dat_b_i = pad_code_t'($random(seed));
      check_word("adc_vld_o", 32'(adc_vld_o), 32'd1);
      check_sample("adc_dat_a_o", adc_dat_a_o, ha);
      check_sample("adc_dat_b_o", adc_dat_b_o, hb);
    end
    adc_rdy_i = 1'b1;
    fill_random_pads(10);
    adc_stream();
    reg_write(8'h40, 32'hFFFF_FFFF);
    reg_read_check(8'h40);
    read_all_regs();
    finish_test("back-pressure and bus error", e0);
  endtask

  initial
  begin
    rst_n_i = 1'b0;
    adc_dat_a_i = '0;
    adc_dat_b_i = '0;
    adc_rdy_i = 1'b1;
    dac_in_a_i = '0;
    dac_in_b_i = '0;
    dac_vld_i = 1'b0;
    sys_addr_i = '0;
    sys_wdata_i = '0;
    sys_wen_i = 1'b0;
    sys_ren_i = 1'b0;
    loop_sh = 1'b0;
    adc_g = '{gain_t'(`RP_GAIN_ONE), gain_t'(`RP_GAIN_ONE)};
    dac_g = '{gain_t'(`RP_GAIN_ONE), gain_t'(`RP_GAIN_ONE)};
    adc_o = '{offset_t'(0), offset_t'(0)};
    dac_o = '{offset_t'(0), offset_t'(0)};
    test_reset_state();
    test_adc_unity();
    test_adc_cal();
    test_dac_path();
    test_loopback();
    test_stall_and_err();
    $display("tests %0d, checks %0d, errors %0d", test_cnt, chk_cnt, err_cnt);
    if (err_cnt == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire
